//--- verilog/gbc_mem_pkg.sv
`default_nettype none

package gbc_mem_pkg;

   // plain widths with a meaning on the bus
   typedef logic [15:0] addr_t;      // cpu address
   typedef logic [7:0]  data_t;      // one byte
   typedef logic [2:0]  bank_t;      // working ram bank number
   typedef logic [14:0] phys_addr_t; // {bank, 12-bit offset}

   // access on the i/o register bus
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we;     // write strobe, wins over re
      logic  re;     // read strobe
   } ioreg_req_t;

   // access from the cpu router into wram or echo
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we;
      logic  re;
   } wram_req_t;

   // registered request into the ram
   typedef struct packed {
      phys_addr_t addr;
      data_t      wdata;
      logic       we;    // write when en, else read
      logic       en;    // stage holds a live access
   } mem_req_t;

endpackage

`default_nettype wire

//--- verilog/io_reg.sv
`timescale 1ns/1ps
`default_nettype none

// single register on the i/o bus, svbk here
module io_reg
   import gbc_mem_pkg::*;
#(
   parameter addr_t REG_ADDR  = 16'hFF70,
   parameter data_t RESET_VAL = 8'h00
) (
   input  logic       clk,
   input  logic       arst_n,
   input  ioreg_req_t req,
   output logic       wr_hit,  // raw write request, gated outside
   input  logic       wr_en,   // gated write back from the control block
   input  data_t      rd_mask, // bits forced high on readback
   output data_t      value,
   output data_t      rdata,
   output logic       rvalid
);

   logic addr_hit;
   logic rd_hit;

   assign addr_hit = (req.addr == REG_ADDR);
   assign wr_hit   = addr_hit & req.we;
   assign rd_hit   = addr_hit & req.re & ~req.we; // we+re counts as a write

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         value  <= RESET_VAL;
         rvalid <= 1'b0;
      end else begin
         if (wr_en) begin
            value <= req.wdata;
         end
         rvalid <= rd_hit; // one cycle after the strobe
      end
   end

   // readback byte, only meaningful with rvalid
   always_ff @(posedge clk) begin
      if (rd_hit) begin
         rdata <= value | rd_mask;
      end
   end

endmodule

`default_nettype wire

//--- verilog/wram_bank_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// bank policy for the switchable half of wram
//
// lower 4 KB (0xC000 window) is always physical bank 0,
// upper 4 KB follows svbk, where 0 means bank 1.
// dmg mode pins the upper half to bank 1 and locks svbk.
module wram_bank_ctrl
   import gbc_mem_pkg::*;
(
   input  logic        dmg_mode,
   input  logic        svbk_wr_hit, // raw write decoded by the register
   output logic        svbk_wr_en,
   input  data_t       svbk,
   input  logic [12:0] offset,      // folded window offset
   output phys_addr_t  phys_addr,
   output data_t       rd_mask
);

   bank_t sel_bank;  // svbk field
   bank_t eff_bank;  // bank for the 0xD000 half
   logic  upper;     // offset in the switchable half

   // no svbk writes on a monochrome console
   assign svbk_wr_en = svbk_wr_hit & ~dmg_mode;

   assign sel_bank = svbk[2:0];

   always_comb begin
      if (dmg_mode) begin
         eff_bank = 3'd1;
      end else if (sel_bank == 3'd0) begin
         eff_bank = 3'd1; // bank 0 can't be mapped twice
      end else begin
         eff_bank = sel_bank;
      end
   end

   assign upper = offset[12];

   // bank in the top bits, byte offset below
   always_comb begin
      if (upper) begin
         phys_addr = {eff_bank, offset[11:0]};
      end else begin
         phys_addr = {3'd0, offset[11:0]};
      end
   end

   // unused svbk bits read as one, all ones on dmg
   always_comb begin
      if (dmg_mode) begin
         rd_mask = 8'hFF;
      end else begin
         rd_mask = 8'hF8;
      end
   end

endmodule

`default_nettype wire

//--- verilog/wram_port.sv
`timescale 1ns/1ps
`default_nettype none

// router side stage in front of the ram
module wram_port
   import gbc_mem_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  wram_req_t   req,
   output logic [12:0] offset,    // registered window offset
   input  phys_addr_t  phys_addr, // mapped address for offset
   output mem_req_t    mem
);

   logic        in_wram;   // 0xC000 - 0xDFFF
   logic        in_echo;   // 0xE000 - 0xFDFF
   logic        accept;
   logic        en_q;
   logic        we_q;
   logic [12:0] offset_q;
   data_t       wdata_q;

   assign in_wram = (req.addr[15:13] == 3'b110);
   assign in_echo = (req.addr >= 16'hE000) && (req.addr < 16'hFE00);

   // anything outside both ranges just disappears
   assign accept = (in_wram | in_echo) & (req.we | req.re);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         en_q <= 1'b0;
         we_q <= 1'b0;
      end else begin
         en_q <= accept;
         we_q <= accept & req.we; // write takes priority over read
      end
   end

   // address and data ride along, qualified by en_q
   // the echo lies 8 KB above the window and shares its low 13 bits
   always_ff @(posedge clk) begin
      if (accept) begin
         offset_q <= req.addr[12:0]; // folds the echo as well
         wdata_q  <= req.wdata;
      end
   end

   assign offset = offset_q; // bank control maps this

   always_comb begin
      mem.addr  = phys_addr;
      mem.wdata = wdata_q;
      mem.we    = we_q;
      mem.en    = en_q;
   end

endmodule

`default_nettype wire

//--- verilog/wram_bram.sv
`timescale 1ns/1ps
`default_nettype none

// single port working ram, BANKS x 4 KB bytes
module wram_bram
   import gbc_mem_pkg::*;
#(
   parameter int BANKS = 8
) (
   input  logic     clk,
   input  logic     arst_n,
   input  mem_req_t mem,
   output data_t    rdata,
   output logic     rvalid
);

   localparam int AW = $clog2(BANKS) + 12; // upper bank bits drop with fewer banks

   data_t ram [BANKS*4096];

   // write or registered read, never both
   always_ff @(posedge clk) begin
      if (mem.en && mem.we) begin
         ram[mem.addr[AW-1:0]] <= mem.wdata;
      end else if (mem.en) begin
         rdata <= ram[mem.addr[AW-1:0]];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rvalid <= 1'b0;
      end else begin
         rvalid <= mem.en & ~mem.we; // pairs with rdata above
      end
   end

endmodule

`default_nettype wire

//--- verilog/gbc_wram_top.sv
`timescale 1ns/1ps
`default_nettype none

// working ram subsystem, colour mode banking with svbk
module gbc_wram_top
   import gbc_mem_pkg::*;
#(
   parameter addr_t SVBK_ADDR = 16'hFF70,
   parameter int    BANKS     = 8
) (
   input  logic       clk,
   input  logic       arst_n,
   input  ioreg_req_t ioreg_req,
   input  logic       dmg_mode,
   input  wram_req_t  wram_req,
   output data_t      ioreg_rdata,
   output logic       ioreg_rvalid,
   output data_t      wram_rdata,
   output logic       wram_rvalid
);

   logic        svbk_wr_hit;  // decoded svbk write
   logic        svbk_wr_en;   // after dmg gating
   data_t       svbk;
   data_t       rd_mask;
   logic [12:0] offset;
   phys_addr_t  phys_addr;
   mem_req_t    mem;

   // bank select register on the i/o bus
   io_reg #(
      .REG_ADDR  (SVBK_ADDR),
      .RESET_VAL (8'h00)
   ) svbk_reg (
      .clk     (clk),
      .arst_n  (arst_n),
      .req     (ioreg_req),
      .wr_hit  (svbk_wr_hit),
      .wr_en   (svbk_wr_en),
      .rd_mask (rd_mask),
      .value   (svbk),
      .rdata   (ioreg_rdata),
      .rvalid  (ioreg_rvalid)
   );

   wram_bank_ctrl bank_ctrl (
      .dmg_mode    (dmg_mode),
      .svbk_wr_hit (svbk_wr_hit),
      .svbk_wr_en  (svbk_wr_en),
      .svbk        (svbk),
      .offset      (offset),
      .phys_addr   (phys_addr),
      .rd_mask     (rd_mask)
   );

   // window check and echo fold, one register deep
   wram_port port (
      .clk       (clk),
      .arst_n    (arst_n),
      .req       (wram_req),
      .offset    (offset),
      .phys_addr (phys_addr),
      .mem       (mem)
   );

   wram_bram #(
      .BANKS (BANKS)
   ) banked_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .mem    (mem),
      .rdata  (wram_rdata),
      .rvalid (wram_rvalid)
   );

endmodule

`default_nettype wire

//--- sim/gbc_wram_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// latency and gating rules, bound into the top level
module gbc_wram_assertions
   import gbc_mem_pkg::*;
#(
   parameter addr_t SVBK_ADDR = 16'hFF70
) (
   input logic       clk,
   input logic       arst_n,
   input ioreg_req_t ioreg_req,
   input wram_req_t  wram_req,
   input logic       dmg_mode,
   input data_t      ioreg_rdata,
   input logic       ioreg_rvalid,
   input logic       wram_rvalid
);

   int unsigned failures = 0; // failed assertion count

   logic wram_rd; // read strobe that must answer
   logic svbk_rd;

   assign wram_rd = wram_req.re & ~wram_req.we
                  & (wram_req.addr >= 16'hC000) & (wram_req.addr < 16'hFE00);
   assign svbk_rd = ioreg_req.re & ~ioreg_req.we & (ioreg_req.addr == SVBK_ADDR);

   wram_latency: assert property (@(posedge clk) disable iff (!arst_n)
         wram_rvalid == $past(wram_rd, 2))
      else begin
         $error("wram_rvalid not exactly two cycles after an in-window read");
         failures++;
      end

   svbk_latency: assert property (@(posedge clk) disable iff (!arst_n)
         ioreg_rvalid == $past(svbk_rd))
      else begin
         $error("ioreg_rvalid not exactly one cycle after an svbk read");
         failures++;
      end

   quiet_in_reset: assert property (@(posedge clk)
         !arst_n |-> (wram_rvalid !== 1'b1) && (ioreg_rvalid !== 1'b1))
      else begin
         $error("valid output high during reset");
         failures++;
      end

   // monochrome console sees an unbanked register
   dmg_readback: assert property (@(posedge clk) disable iff (!arst_n)
         (dmg_mode && ioreg_rvalid) |-> ioreg_rdata == 8'hFF)
      else begin
         $error("svbk readback not 0xFF in dmg mode");
         failures++;
      end

endmodule

bind gbc_wram_top gbc_wram_assertions #(
   .SVBK_ADDR (SVBK_ADDR)
) chk (.*);

`default_nettype wire

//--- sim/tb_gbc_wram.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gbc_wram
   import gbc_mem_pkg::*;
();

   localparam addr_t SVBK_ADDR = 16'hFF70;

   logic       clk = 1'b0;
   logic       arst_n = 1'b0;
   ioreg_req_t ioreg_req = '0;
   wram_req_t  wram_req = '0;
   logic       dmg_mode = 1'b0;
   data_t      ioreg_rdata;
   logic       ioreg_rvalid;
   data_t      wram_rdata;
   logic       wram_rvalid;

   data_t model [32768];         // expected ram contents
   data_t ref_svbk = 8'h00;
   logic  ref_dmg = 1'b0;
   data_t exp_wram [$];
   int    exp_wram_cyc [$];      // strobe cycle per read
   data_t exp_io [$];
   int    exp_io_cyc [$];
   int    cyc = 0;
   int    errors = 0;
   int    checks = 0;
   int    seed = 32'h783a_ff7a;
   string test_name = "reset";

   gbc_wram_top #(
      .SVBK_ADDR (SVBK_ADDR),
      .BANKS     (8)
   ) UUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .ioreg_req    (ioreg_req),
      .dmg_mode     (dmg_mode),
      .wram_req     (wram_req),
      .ioreg_rdata  (ioreg_rdata),
      .ioreg_rvalid (ioreg_rvalid),
      .wram_rdata   (wram_rdata),
      .wram_rvalid  (wram_rvalid)
   );

   always #50 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic in_window(input addr_t a);
      return (a >= 16'hC000) && (a < 16'hFE00); // wram plus echo
   endfunction

   // mapping rule, bank 0 low half, svbk (0 -> 1) high half, dmg pins bank 1
   function automatic phys_addr_t ref_phys(input addr_t a);
      addr_t f;
      bank_t bank;
      f = (a >= 16'hE000) ? a - 16'h2000 : a; // echo mirror
      if (f < 16'hD000) begin
         bank = 3'd0;
      end else if (ref_dmg || ref_svbk[2:0] == 3'd0) begin
         bank = 3'd1;
      end else begin
         bank = ref_svbk[2:0];
      end
      return {bank, f[11:0]};
   endfunction

   function automatic data_t ref_byte(input addr_t a);
      return model[ref_phys(a)];
   endfunction

   function automatic data_t ref_svbk_read();
      return ref_dmg ? 8'hFF : (ref_svbk | 8'hF8);
   endfunction

   // one strobe on the router bus
   task automatic wram_access(input addr_t a, input data_t d, input logic we);
      @(posedge clk);
      wram_req  <= '{addr: a, wdata: d, we: we, re: ~we};
      ioreg_req <= '0;
      if (in_window(a)) begin
         if (we) begin
            model[ref_phys(a)] = d;
         end else begin
            exp_wram.push_back(ref_byte(a));
            exp_wram_cyc.push_back(cyc + 1);
         end
      end
   endtask

   task automatic io_access(input data_t d, input logic we);
      @(posedge clk);
      ioreg_req <= '{addr: SVBK_ADDR, wdata: d, we: we, re: ~we};
      wram_req  <= '0;
      if (we && !ref_dmg) begin
         ref_svbk = d; // dmg drops it
      end else if (!we) begin
         exp_io.push_back(ref_svbk_read());
         exp_io_cyc.push_back(cyc + 1);
      end
   endtask

   // idle both buses until every read has answered
   task automatic drain();
      int waited;
      waited = 0;
      @(posedge clk);
      wram_req  <= '0;
      ioreg_req <= '0;
      while (exp_wram.size() + exp_io.size() != 0 && waited < 100) begin
         @(posedge clk);
         waited++;
      end
      if (exp_wram.size() + exp_io.size() != 0) begin
         $display("%s: timed out with %0d read responses missing", test_name,
                  exp_wram.size() + exp_io.size());
         $display("=== FAIL ===");
         $finish;
      end else begin
         repeat (2) @(posedge clk); // window for stray valids
      end
   endtask

   task automatic end_test(input int base);
      drain();
      $display("test %-10s %s, %0d errors", test_name,
               (errors == base) ? "passed" : "failed", errors - base);
   endtask

   // oldest expectation, value and latency
   task automatic check_resp(input string bus, input data_t actual, input int lat,
                             ref data_t exp_q [$], ref int cyc_q [$]);
      data_t want;
      int    issued;
      if (exp_q.size() == 0) begin
         $display("%s: %s read data arrived with no read outstanding", test_name, bus);
         errors++;
      end else begin
         want   = exp_q.pop_front();
         issued = cyc_q.pop_front();
         checks++;
         if (actual !== want) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, bus, want, actual);
            errors++;
         end
         if (cyc != issued + lat) begin
            $display("%s: %s data came %0d cycles after its strobe", test_name, bus,
                     cyc - issued);
            errors++;
         end
      end
   endtask

   // outputs settle on the rising edge, look at them on the falling one
   always @(negedge clk) begin
      if (!arst_n && (wram_rvalid === 1'b1 || ioreg_rvalid === 1'b1)) begin
         $display("a valid output is high while reset is asserted");
         errors++;
      end
      if (arst_n && wram_rvalid) check_resp("wram", wram_rdata, 2, exp_wram, exp_wram_cyc);
      if (arst_n && ioreg_rvalid) check_resp("svbk", ioreg_rdata, 1, exp_io, exp_io_cyc);
   end

   initial begin
      int    base;
      int    k;
      int    r;
      addr_t picks [16];
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      test_name = "reset";
      base = errors;
      io_access(8'h00, 1'b0);           // 0xF8 expected
      wram_access(16'hD000, 8'h5A, 1'b1); // svbk 0 -> bank 1
      io_access(8'h01, 1'b1);
      wram_access(16'hD000, 8'h00, 1'b0);
      end_test(base);

      test_name = "banks";
      base = errors;
      wram_access(16'hC123, 8'h3C, 1'b1);
      for (k = 1; k < 8; k++) begin
         io_access(k[7:0], 1'b1);
         wram_access(16'hD123, 8'hA0 + k[7:0], 1'b1);
      end
      for (k = 7; k >= 1; k--) begin
         io_access(k[7:0], 1'b1);
         io_access(8'h00, 1'b0);
         wram_access(16'hD123, 8'h00, 1'b0);
      end
      wram_access(16'hC123, 8'h00, 1'b0); // bank 0 untouched
      end_test(base);

      test_name = "echo";
      base = errors;
      r = $random(seed);
      k = r & 32'h07FF;                    // keeps 0xF000 + k below 0xFE00
      io_access(8'h03, 1'b1);
      wram_access(16'hE000 + k[15:0], 8'hC7, 1'b1);
      wram_access(16'hC000 + k[15:0], 8'h00, 1'b0);
      wram_access(16'hD000 + k[15:0], 8'h33, 1'b1);
      wram_access(16'hF000 + k[15:0], 8'h00, 1'b0);
      io_access(8'h06, 1'b1);
      wram_access(16'hD000 + k[15:0], 8'h66, 1'b1);
      wram_access(16'hF000 + k[15:0], 8'h00, 1'b0);
      io_access(8'h03, 1'b1);
      wram_access(16'hF000 + k[15:0], 8'h00, 1'b0);
      end_test(base);

      test_name = "dmg";
      base = errors;
      io_access(8'h01, 1'b1);
      wram_access(16'hD200, 8'h11, 1'b1);
      io_access(8'h05, 1'b1);
      wram_access(16'hD200, 8'h55, 1'b1);
      drain();
      @(posedge clk);
      dmg_mode <= 1'b1;
      ref_dmg = 1'b1;
      io_access(8'h00, 1'b0);
      io_access(8'h02, 1'b1);             // ignored
      io_access(8'h00, 1'b0);
      wram_access(16'hD200, 8'h00, 1'b0); // bank 1, not 5
      wram_access(16'hD300, 8'h77, 1'b1);
      wram_access(16'hF300, 8'h00, 1'b0);
      drain();
      @(posedge clk);
      dmg_mode <= 1'b0;
      ref_dmg = 1'b0;
      io_access(8'h00, 1'b0);             // svbk 5 survived
      wram_access(16'hD200, 8'h00, 1'b0);
      end_test(base);

      test_name = "window";
      base = errors;
      wram_access(16'hD000, 8'h01, 1'b1);
      wram_access(16'hDE00, 8'h02, 1'b1);
      wram_access(16'hB000, 8'hE1, 1'b1); // would alias 0xD000
      wram_access(16'hFE00, 8'hE2, 1'b1); // would alias 0xDE00
      wram_access(16'hB000, 8'h00, 1'b0);
      wram_access(16'hFE00, 8'h00, 1'b0);
      wram_access(16'hD000, 8'h00, 1'b0);
      wram_access(16'hDE00, 8'h00, 1'b0);
      for (k = 0; k < 16; k++) begin
         r = $random(seed);
         picks[k] = 16'hC000 | r[12:0];
         r = $random(seed);
         wram_access(picks[k], r[7:0], 1'b1);
      end
      for (k = 0; k < 16; k++) begin
         r = $random(seed);
         wram_access(picks[r[3:0]], 8'h00, 1'b0); // back to back
      end
      end_test(base);

      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               UUT.chk.failures);
      if (errors == 0 && UUT.chk.failures == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
verilog/gbc_mem_pkg.sv
verilog/io_reg.sv
verilog/wram_bank_ctrl.sv
verilog/wram_port.sv
verilog/wram_bram.sv
verilog/gbc_wram_top.sv
sim/gbc_wram_assertions.sv
sim/tb_gbc_wram.sv

//--- Bender.yml
package:
  name: gbc_wram

sources:
  - files:
      - verilog/gbc_mem_pkg.sv
      - verilog/io_reg.sv
      - verilog/wram_bank_ctrl.sv
      - verilog/wram_port.sv
      - verilog/wram_bram.sv
      - verilog/gbc_wram_top.sv
  - target: simulation
    files:
      - sim/gbc_wram_assertions.sv
      - sim/tb_gbc_wram.sv
